/* logic/wb_settings.svh */
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// pending memory writes held between retire and drain
`define WB_QDEPTH 4

`define WB_MEM_LAT 3 // cycles per drained write

`define WB_NREGS 8 // general and segment files alike
`define WB_RAW $clog2(`WB_NREGS)

`define WB_DW 64 // slot data
`define WB_AW 32 // addresses, eip
`define WB_SW 16 // segment selector
`define WB_FW 18 // eflags

`endif

/* logic/wb_types_pkg.sv */
package wb_types_pkg;

    typedef enum logic [2:0] {
        op_plain    = 3'd0,
        op_halt     = 3'd1,
        op_far_jmp  = 3'd2, // loads cs:eip
        op_far_call = 3'd3, // loads cs:eip
        op_iret     = 3'd4  // loads cs:eip
    } p_op_e;

    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_reg  = 2'd1,
        kind_seg  = 2'd2,
        kind_mem  = 2'd3
    } slot_kind_e;

    typedef enum logic [1:0] {
        sz_8  = 2'd0,
        sz_16 = 2'd1,
        sz_32 = 2'd2,
        sz_64 = 2'd3
    } opsize_e;

endpackage

/* logic/wb_ctrl_pkg.sv */
package wb_ctrl_pkg;

    typedef enum logic [1:0] {
        st_run    = 2'd0,
        st_halted = 2'd1,
        st_fault  = 2'd2
    } wb_state_e;

    // bit 3 set for an interrupt, cause in 2:0
    typedef enum logic [3:0] {
        exc_none = 4'h0,
        exc_div  = 4'h1,
        exc_ud   = 4'h2,
        exc_gp   = 4'h3,
        exc_pf   = 4'h4,
        exc_intr = 4'h8
    } exc_type_e;

endpackage

/* logic/wb_route.sv */
`include "wb_settings.svh"

module wb_route (
    input  logic                        clk,
    input  logic                        valid_in,
    input  wb_types_pkg::p_op_e         p_op,
    input  logic                        retire_en,
    input  logic [`WB_DW-1:0]           slot1_data,
    input  logic [`WB_DW-1:0]           slot2_data,
    input  logic [`WB_DW-1:0]           slot3_data,
    input  logic [`WB_DW-1:0]           slot4_data,
    input  logic [`WB_AW-1:0]           slot1_dest,
    input  logic [`WB_AW-1:0]           slot2_dest,
    input  logic [`WB_AW-1:0]           slot3_dest,
    input  logic [`WB_AW-1:0]           slot4_dest,
    input  wb_types_pkg::slot_kind_e    slot1_kind,
    input  wb_types_pkg::slot_kind_e    slot2_kind,
    input  wb_types_pkg::slot_kind_e    slot3_kind,
    input  wb_types_pkg::slot_kind_e    slot4_kind,
    input  logic                        slot1_wb,
    input  logic                        slot2_wb,
    input  logic                        slot3_wb,
    input  logic                        slot4_wb,
    input  wb_types_pkg::opsize_e       size,
    input  logic [`WB_AW-1:0]           eip_in,
    input  logic                        br_valid,
    input  logic                        br_taken,
    input  logic                        br_correct,
    input  logic [`WB_AW-1:0]           br_target,
    input  logic                        q_full,
    output logic                        valid_out,
    output logic                        stall,
    output logic                        resteer,
    output logic [`WB_AW-1:0]           new_eip,
    output logic                        ld_eip_cs,
    output logic [3:0]                  reg_we,
    output logic [3:0]                  seg_we,
    output logic [4*`WB_RAW-1:0]        reg_addr,
    output logic [4*`WB_RAW-1:0]        seg_addr,
    output logic [`WB_DW-1:0]           reg_data1,
    output logic [`WB_DW-1:0]           reg_data2,
    output logic [`WB_DW-1:0]           reg_data3,
    output logic [`WB_DW-1:0]           reg_data4,
    output logic                        push,
    output logic [`WB_AW-1:0]           push_addr,
    output logic [`WB_DW-1:0]           push_data,
    output wb_types_pkg::opsize_e       push_size
);
    import wb_types_pkg::*;

    logic [`WB_DW-1:0] data [4];
    logic [`WB_AW-1:0] dest [4];
    slot_kind_e        kind [4];
    logic [3:0]        wb;
    logic [3:0]        mem_req; // memory slot wanting the queue

    assign data = '{slot1_data, slot2_data, slot3_data, slot4_data};
    assign dest = '{slot1_dest, slot2_dest, slot3_dest, slot4_dest};
    assign kind = '{slot1_kind, slot2_kind, slot3_kind, slot4_kind};
    assign wb   = {slot4_wb, slot3_wb, slot2_wb, slot1_wb};

    for (genvar i = 0; i < 4; i++) begin : g_addr
        assign reg_addr[i*`WB_RAW +: `WB_RAW] = dest[i][`WB_RAW-1:0];
        assign seg_addr[i*`WB_RAW +: `WB_RAW] = dest[i][`WB_RAW-1:0];
    end

    always_comb begin
        ld_eip_cs = p_op inside {op_far_jmp, op_far_call, op_iret};
        for (int i = 0; i < 4; i++) begin
            mem_req[i] = valid_in && retire_en && wb[i] && kind[i] == kind_mem;
        end
        stall     = q_full && |mem_req;
        valid_out = valid_in && retire_en && !stall;
        for (int i = 0; i < 4; i++) begin
            reg_we[i] = valid_out && wb[i] && kind[i] == kind_reg;
            seg_we[i] = valid_out && wb[i] && kind[i] == kind_seg;
        end
        push      = valid_out && |mem_req;
        push_addr = '0;
        push_data = '0;
        for (int i = 0; i < 4; i++) begin
            if (mem_req[i]) begin
                push_addr = dest[i];
                push_data = data[i];
            end
        end
        push_size = ld_eip_cs ? sz_64 : size; // far pointer stored whole
    end

    // selector split out of slot 1 for far transfers
    assign reg_data1 = ld_eip_cs ? {{(`WB_DW-16){1'b0}}, slot1_data[47:32]} : slot1_data;
    assign reg_data2 = slot2_data;
    assign reg_data3 = slot3_data;
    assign reg_data4 = slot4_data;

    always_comb begin
        if (!br_taken) begin
            new_eip = eip_in;
        end else if (ld_eip_cs) begin
            new_eip = slot1_data[`WB_AW-1:0];
        end else begin
            new_eip = br_target;
        end
    end

    assign resteer = valid_out && br_valid && !br_correct;

    // the queue takes one entry per instruction
    a_one_mem_slot: assert property (@(posedge clk) valid_in |-> $onehot0(mem_req));

endmodule

/* logic/arch_state.sv */
`include "wb_settings.svh"

module arch_state (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [3:0]              reg_we,
    input  logic [4*`WB_RAW-1:0]    reg_addr,
    input  logic [`WB_DW-1:0]       reg_data1,
    input  logic [`WB_DW-1:0]       reg_data2,
    input  logic [`WB_DW-1:0]       reg_data3,
    input  logic [`WB_DW-1:0]       reg_data4,
    input  logic [3:0]              seg_we,
    input  logic [4*`WB_RAW-1:0]    seg_addr,
    input  logic                    eip_we,
    input  logic [`WB_AW-1:0]       new_eip,
    input  logic                    ld_eip_cs,
    input  logic [`WB_FW-1:0]       eflags_in,
    input  logic [`WB_RAW-1:0]      gpr_rd_addr,
    input  logic [`WB_RAW-1:0]      seg_rd_addr,
    output logic [`WB_DW-1:0]       gpr_rd_data,
    output logic [`WB_SW-1:0]       seg_rd_data,
    output logic [`WB_AW-1:0]       eip,
    output logic [`WB_SW-1:0]       cs,
    output logic [`WB_FW-1:0]       eflags
);
    logic [`WB_DW-1:0] gpr   [`WB_NREGS];
    logic [`WB_SW-1:0] seg   [`WB_NREGS];
    logic [`WB_DW-1:0] wdata [4];

    assign wdata = '{reg_data1, reg_data2, reg_data3, reg_data4};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < `WB_NREGS; r++) begin
                gpr[r] <= '0;
                seg[r] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin // slot 4 written last, wins
                if (reg_we[i]) begin
                    gpr[reg_addr[i*`WB_RAW +: `WB_RAW]] <= wdata[i];
                end
                if (seg_we[i]) begin
                    seg[seg_addr[i*`WB_RAW +: `WB_RAW]] <= wdata[i][`WB_SW-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eip    <= '0;
            cs     <= '0;
            eflags <= '0;
        end else if (eip_we) begin
            eip    <= new_eip;
            eflags <= eflags_in;
            if (ld_eip_cs) begin
                cs <= reg_data1[`WB_SW-1:0]; // selector already split out
            end
        end
    end

    assign gpr_rd_data = gpr[gpr_rd_addr];
    assign seg_rd_data = seg[seg_rd_addr];

endmodule

/* logic/wb_write_queue.sv */
`include "wb_settings.svh"

module wb_write_queue (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    push,
    input  logic [`WB_AW-1:0]       push_addr,
    input  logic [`WB_DW-1:0]       push_data,
    input  wb_types_pkg::opsize_e   push_size,
    input  logic                    pop,
    output logic                    q_full,
    output logic                    q_empty,
    output logic [`WB_AW-1:0]       head_addr,
    output logic [`WB_DW-1:0]       head_data,
    output wb_types_pkg::opsize_e   head_size
);
    import wb_types_pkg::*;

    localparam int PW = $clog2(`WB_QDEPTH);
    localparam int CW = $clog2(`WB_QDEPTH + 1);

    logic [`WB_AW-1:0] addr_q [`WB_QDEPTH];
    logic [`WB_DW-1:0] data_q [`WB_QDEPTH];
    opsize_e           size_q [`WB_QDEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     count;

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= push_addr;
            data_q[wr_ptr] <= push_data;
            size_q[wr_ptr] <= push_size;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(`WB_QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(`WB_QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    assign q_full    = count == CW'(`WB_QDEPTH);
    assign q_empty   = count == '0;
    assign head_addr = addr_q[rd_ptr];
    assign head_data = data_q[rd_ptr];
    assign head_size = size_q[rd_ptr];

    // router stall must hold back the push
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) q_full |-> !push);
    // drain timer only runs on a non-empty queue
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) q_empty |-> !pop);

endmodule

/* logic/mem_drain_timer.sv */
`include "wb_settings.svh"

module mem_drain_timer (
    input  logic clk,
    input  logic arst_n,
    input  logic q_empty,
    output logic pop
);
    localparam int CW = $clog2(`WB_MEM_LAT + 1);

    logic          busy;
    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (!busy && !q_empty) begin
            busy <= 1'b1;
            cnt  <= CW'(`WB_MEM_LAT - 1);
        end else if (pop) begin
            busy <= 1'b0; // reload next cycle if entries remain
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign pop = busy && cnt == '0;

endmodule

/* logic/wb_fsm.sv */
module wb_fsm (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    valid_in,
    input  wb_types_pkg::p_op_e     p_op,
    input  logic                    ie_in,
    input  logic [2:0]              ie_cause,
    input  logic                    interrupt_in,
    input  logic                    fault_clear,
    output logic                    retire_en,
    output logic                    halted,
    output logic                    fault_val,
    output wb_ctrl_pkg::exc_type_e  fault_type
);
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    wb_state_e state;
    logic      exc; // exception merged with interrupt

    assign exc = ie_in || interrupt_in;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_run;
            fault_type <= exc_none;
        end else begin
            case (state)
                st_run: begin
                    if (valid_in && exc) begin
                        state      <= st_fault;
                        fault_type <= exc_type_e'({interrupt_in, ie_cause});
                    end else if (valid_in && p_op == op_halt) begin
                        state <= st_halted;
                    end
                end
                st_halted: begin
                    if (interrupt_in) begin
                        state <= st_run;
                    end
                end
                st_fault: begin
                    if (fault_clear) begin
                        state <= st_run;
                    end
                end
                default: state <= st_run;
            endcase
        end
    end

    assign retire_en = state == st_run && !exc;
    assign halted    = state == st_halted;
    assign fault_val = state == st_fault;

endmodule

/* logic/wb_top.sv */
`include "wb_settings.svh"

module wb_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        valid_in,
    input  wb_types_pkg::p_op_e         p_op,
    input  logic [`WB_AW-1:0]           eip_in,
    input  logic [`WB_FW-1:0]           eflags_in,
    input  logic [`WB_DW-1:0]           slot1_data,
    input  logic [`WB_DW-1:0]           slot2_data,
    input  logic [`WB_DW-1:0]           slot3_data,
    input  logic [`WB_DW-1:0]           slot4_data,
    input  logic [`WB_AW-1:0]           slot1_dest,
    input  logic [`WB_AW-1:0]           slot2_dest,
    input  logic [`WB_AW-1:0]           slot3_dest,
    input  logic [`WB_AW-1:0]           slot4_dest,
    input  wb_types_pkg::slot_kind_e    slot1_kind,
    input  wb_types_pkg::slot_kind_e    slot2_kind,
    input  wb_types_pkg::slot_kind_e    slot3_kind,
    input  wb_types_pkg::slot_kind_e    slot4_kind,
    input  logic                        slot1_wb,
    input  logic                        slot2_wb,
    input  logic                        slot3_wb,
    input  logic                        slot4_wb,
    input  wb_types_pkg::opsize_e       size,
    input  logic                        br_valid,
    input  logic                        br_taken,
    input  logic                        br_correct,
    input  logic [`WB_AW-1:0]           br_target,
    input  logic                        ie_in,
    input  logic [2:0]                  ie_cause,
    input  logic                        interrupt_in,
    input  logic                        fault_clear,
    input  logic [`WB_RAW-1:0]          gpr_rd_addr,
    input  logic [`WB_RAW-1:0]          seg_rd_addr,
    output logic                        valid_out,
    output logic                        stall,
    output logic                        resteer,
    output logic [`WB_AW-1:0]           new_eip,
    output logic                        mem_wr,
    output logic [`WB_AW-1:0]           mem_wr_addr,
    output logic [`WB_DW-1:0]           mem_wr_data,
    output wb_types_pkg::opsize_e       mem_wr_size,
    output logic [`WB_DW-1:0]           gpr_rd_data,
    output logic [`WB_SW-1:0]           seg_rd_data,
    output logic [`WB_AW-1:0]           eip,
    output logic [`WB_SW-1:0]           cs,
    output logic [`WB_FW-1:0]           eflags,
    output logic                        halted,
    output logic                        fault_val,
    output wb_ctrl_pkg::exc_type_e      fault_type
);
    import wb_types_pkg::*;

    logic                   retire_en;
    logic                   ld_eip_cs;
    logic [3:0]             reg_we;
    logic [3:0]             seg_we;
    logic [4*`WB_RAW-1:0]   reg_addr;
    logic [4*`WB_RAW-1:0]   seg_addr;
    logic [`WB_DW-1:0]      reg_data1;
    logic [`WB_DW-1:0]      reg_data2;
    logic [`WB_DW-1:0]      reg_data3;
    logic [`WB_DW-1:0]      reg_data4;
    logic                   push;
    logic [`WB_AW-1:0]      push_addr;
    logic [`WB_DW-1:0]      push_data;
    opsize_e                push_size;
    logic                   q_full;
    logic                   q_empty;

    wb_route route_i (
        .clk, .valid_in, .p_op, .retire_en,
        .slot1_data, .slot2_data, .slot3_data, .slot4_data,
        .slot1_dest, .slot2_dest, .slot3_dest, .slot4_dest,
        .slot1_kind, .slot2_kind, .slot3_kind, .slot4_kind,
        .slot1_wb, .slot2_wb, .slot3_wb, .slot4_wb, .size,
        .eip_in, .br_valid, .br_taken, .br_correct, .br_target, .q_full,
        .valid_out, .stall, .resteer, .new_eip, .ld_eip_cs,
        .reg_we, .seg_we, .reg_addr, .seg_addr,
        .reg_data1, .reg_data2, .reg_data3, .reg_data4,
        .push, .push_addr, .push_data, .push_size
    );

    arch_state state_i (
        .clk, .arst_n, .reg_we, .reg_addr,
        .reg_data1, .reg_data2, .reg_data3, .reg_data4,
        .seg_we, .seg_addr,
        .eip_we (valid_out), // commit at end of retire cycle
        .new_eip, .ld_eip_cs, .eflags_in, .gpr_rd_addr, .seg_rd_addr,
        .gpr_rd_data, .seg_rd_data, .eip, .cs, .eflags
    );

    wb_write_queue queue_i (
        .clk, .arst_n, .push, .push_addr, .push_data, .push_size,
        .pop       (mem_wr),
        .q_full, .q_empty,
        .head_addr (mem_wr_addr),
        .head_data (mem_wr_data),
        .head_size (mem_wr_size)
    );

    mem_drain_timer timer_i (
        .clk, .arst_n, .q_empty,
        .pop (mem_wr)
    );

    wb_fsm fsm_i (
        .clk, .arst_n, .valid_in, .p_op, .ie_in, .ie_cause, .interrupt_in, .fault_clear,
        .retire_en, .halted, .fault_val, .fault_type
    );

endmodule

/* bench/wb_tb.sv */
`include "wb_settings.svh"

module wb_tb;
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    localparam int N_INSTR = 40 + 20 + 20 + 30 + 8;
    localparam int LIMIT   = N_INSTR * (`WB_MEM_LAT + 2) + 200;
    localparam int RAW     = `WB_RAW;

    logic clk;
    logic arst_n;
    logic valid_in;
    p_op_e p_op;
    logic [`WB_AW-1:0] eip_in;
    logic [`WB_FW-1:0] eflags_in;
    logic [`WB_DW-1:0] slot1_data, slot2_data, slot3_data, slot4_data;
    logic [`WB_AW-1:0] slot1_dest, slot2_dest, slot3_dest, slot4_dest;
    slot_kind_e slot1_kind, slot2_kind, slot3_kind, slot4_kind;
    logic slot1_wb, slot2_wb, slot3_wb, slot4_wb;
    opsize_e size;
    logic br_valid, br_taken, br_correct;
    logic [`WB_AW-1:0] br_target;
    logic ie_in, interrupt_in, fault_clear;
    logic [2:0] ie_cause;
    logic [`WB_RAW-1:0] gpr_rd_addr, seg_rd_addr;

    logic valid_out, stall, resteer, mem_wr, halted, fault_val;
    logic [`WB_AW-1:0] new_eip, mem_wr_addr, eip;
    logic [`WB_DW-1:0] mem_wr_data, gpr_rd_data;
    logic [`WB_SW-1:0] seg_rd_data, cs;
    logic [`WB_FW-1:0] eflags;
    opsize_e mem_wr_size;
    exc_type_e fault_type;

    wb_top dut_i (.*);

    // next instruction, built by the tests
    logic [`WB_DW-1:0] n_data [4];
    logic [`WB_AW-1:0] n_dest [4];
    slot_kind_e        n_kind [4];
    logic [3:0]        n_wb;

    // reference model
    logic [`WB_DW-1:0] m_gpr [`WB_NREGS];
    logic [`WB_SW-1:0] m_seg [`WB_NREGS];
    logic [`WB_AW-1:0] m_eip;
    logic [`WB_SW-1:0] m_cs;
    logic [`WB_FW-1:0] m_eflags;
    wb_state_e         m_st;
    exc_type_e         m_type;
    logic [`WB_AW-1:0] q_addr [$];
    logic [`WB_DW-1:0] q_data [$];
    opsize_e           q_size [$];

    logic [`WB_DW-1:0] cur_data [4];
    logic [`WB_AW-1:0] cur_dest [4];
    slot_kind_e        cur_kind [4];
    logic [3:0]        cur_wb;

    logic [31:0] lfsr_state = 32'hc8b4;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_err0;
    int cycles = 0;
    int last_pop = -100;
    int pushes = 0;
    int pops = 0;
    string cur_test = "reset";

    assign cur_data = '{slot1_data, slot2_data, slot3_data, slot4_data};
    assign cur_dest = '{slot1_dest, slot2_dest, slot3_dest, slot4_dest};
    assign cur_kind = '{slot1_kind, slot2_kind, slot3_kind, slot4_kind};
    assign cur_wb   = {slot4_wb, slot3_wb, slot2_wb, slot1_wb};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [63:0] lfsr_bits(int n);
        logic [63:0] r;
        logic b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) lfsr_state = lfsr_state ^ 32'h80200003;
            r[i] = b;
        end
        return r;
    endfunction

    task automatic count_check(bit ok, string msg);
        checks++;
        if (!ok) begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic check_reg(string what, logic [`WB_DW-1:0] exp, logic [`WB_DW-1:0] act);
        count_check(exp === act, $sformatf("Mismatch %s %s: expected %h actual %h",
                    cur_test, what, exp, act));
    endtask

    task automatic check_seg(string what, logic [`WB_SW-1:0] exp, logic [`WB_SW-1:0] act);
        count_check(exp === act, $sformatf("Mismatch %s %s: expected %h actual %h",
                    cur_test, what, exp, act));
    endtask

    task automatic check_eip(string what, logic [`WB_AW-1:0] exp, logic [`WB_AW-1:0] act);
        count_check(exp === act, $sformatf("Mismatch %s %s: expected %h actual %h",
                    cur_test, what, exp, act));
    endtask

    task automatic check_eflags(string what, logic [`WB_FW-1:0] exp, logic [`WB_FW-1:0] act);
        count_check(exp === act, $sformatf("Mismatch %s %s: expected %h actual %h",
                    cur_test, what, exp, act));
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        count_check(exp === act, $sformatf("Mismatch %s %s: expected %b actual %b",
                    cur_test, what, exp, act));
    endtask

    task automatic check_mem(logic [`WB_AW-1:0] ea, logic [`WB_DW-1:0] ed, opsize_e es,
                             logic [`WB_AW-1:0] aa, logic [`WB_DW-1:0] ad, opsize_e as_);
        count_check(ea === aa && ed === ad && es === as_,
                    $sformatf("Mismatch %s mem write: expected %h/%h/%s actual %h/%h/%s",
                              cur_test, ea, ed, es.name(), aa, ad, as_.name()));
    endtask

    task automatic check_state(logic eh, logic ef, exc_type_e et,
                               logic ah, logic af, exc_type_e at);
        count_check(eh === ah && ef === af && (!ef || et === at),
                    $sformatf("Mismatch %s state: expected h%b f%b %h actual h%b f%b %h",
                              cur_test, eh, ef, et, ah, af, at));
    endtask

    // compare on the falling edge, then advance the model
    always @(negedge clk) begin : monitor
        logic ren, far, mem_any, e_stall, e_valid;
        logic [`WB_AW-1:0] e_eip;
        logic [`WB_DW-1:0] d;
        int mi;
        if (arst_n) begin
            far = p_op inside {op_far_jmp, op_far_call, op_iret};
            ren = m_st == st_run && !ie_in && !interrupt_in;
            mem_any = 1'b0;
            mi = 0;
            for (int i = 0; i < 4; i++) begin
                if (cur_wb[i] && cur_kind[i] == kind_mem) begin
                    mem_any = 1'b1;
                    mi = i;
                end
            end
            e_stall = valid_in && ren && mem_any && q_addr.size() == `WB_QDEPTH;
            e_valid = valid_in && ren && !e_stall;
            e_eip = !br_taken ? eip_in : far ? slot1_data[`WB_AW-1:0] : br_target;
            check_flag("stall", e_stall, stall);
            check_flag("valid_out", e_valid, valid_out);
            check_flag("resteer", e_valid && br_valid && !br_correct, resteer);
            if (valid_in) check_eip("new_eip", e_eip, new_eip);
            check_reg("gpr read", m_gpr[gpr_rd_addr], gpr_rd_data);
            check_seg("seg read", m_seg[seg_rd_addr], seg_rd_data);
            check_eip("eip", m_eip, eip);
            check_seg("cs", m_cs, cs);
            check_eflags("eflags", m_eflags, eflags);
            check_state(m_st == st_halted, m_st == st_fault, m_type, halted, fault_val,
                        fault_type);
            if (mem_wr) begin
                if (q_addr.size() == 0) begin
                    count_check(1'b0, $sformatf("%s: memory write with nothing pending",
                                                cur_test));
                end else begin
                    check_mem(q_addr[0], q_data[0], q_size[0],
                              mem_wr_addr, mem_wr_data, mem_wr_size);
                    void'(q_addr.pop_front());
                    void'(q_data.pop_front());
                    void'(q_size.pop_front());
                end
                count_check(cycles - last_pop >= `WB_MEM_LAT,
                            $sformatf("%s: memory writes only %0d cycles apart",
                                      cur_test, cycles - last_pop));
                last_pop = cycles;
                pops++;
            end
            if (e_valid) begin
                for (int i = 0; i < 4; i++) begin
                    d = (i == 0 && far) ? {48'h0, cur_data[0][47:32]} : cur_data[i];
                    if (cur_wb[i] && cur_kind[i] == kind_reg) m_gpr[cur_dest[i][2:0]] = d;
                    if (cur_wb[i] && cur_kind[i] == kind_seg) m_seg[cur_dest[i][2:0]] = d[15:0];
                end
                m_eip = e_eip;
                m_eflags = eflags_in;
                if (far) m_cs = slot1_data[47:32];
                if (mem_any) begin
                    q_addr.push_back(cur_dest[mi]);
                    q_data.push_back(cur_data[mi]);
                    q_size.push_back(far ? sz_64 : size);
                    pushes++;
                end
            end
            case (m_st)
                st_run: begin
                    if (valid_in && (ie_in || interrupt_in)) begin
                        m_st = st_fault;
                        m_type = exc_type_e'({interrupt_in, ie_cause});
                    end else if (valid_in && p_op == op_halt) begin
                        m_st = st_halted;
                    end
                end
                st_halted: if (interrupt_in) m_st = st_run;
                default:   if (fault_clear) m_st = st_run;
            endcase
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run exceeded %0d cycles", LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // mem_mode 0 no memory slot, 1 maybe one, 2 exactly one
    task automatic random_slots(int dbits, int mem_mode);
        bit have_mem;
        int ms;
        have_mem = 0;
        ms = int'(lfsr_bits(2));
        for (int i = 0; i < 4; i++) begin
            n_kind[i] = slot_kind_e'(2'(lfsr_bits(2)));
            if (n_kind[i] == kind_mem && (mem_mode != 1 || have_mem)) n_kind[i] = kind_reg;
            if (n_kind[i] == kind_mem) have_mem = 1;
            n_wb[i] = 1'(lfsr_bits(1));
            n_data[i] = lfsr_bits(64);
            n_dest[i] = `WB_AW'(lfsr_bits(`WB_AW));
            if (n_kind[i] != kind_mem) n_dest[i] = n_dest[i] & ((32'd1 << dbits) - 1);
        end
        if (mem_mode == 2) begin
            n_kind[ms] = kind_mem;
            n_wb[ms] = 1'b1;
        end
    endtask

    task automatic drive_instr(logic v, p_op_e op, bit hold, logic ie, logic intr,
                               logic clr);
        @(posedge clk);
        valid_in <= v;
        p_op <= op;
        eip_in <= `WB_AW'(lfsr_bits(`WB_AW));
        eflags_in <= `WB_FW'(lfsr_bits(`WB_FW));
        size <= opsize_e'(2'(lfsr_bits(2)));
        slot1_data <= n_data[0];
        slot2_data <= n_data[1];
        slot3_data <= n_data[2];
        slot4_data <= n_data[3];
        slot1_dest <= n_dest[0];
        slot2_dest <= n_dest[1];
        slot3_dest <= n_dest[2];
        slot4_dest <= n_dest[3];
        slot1_kind <= n_kind[0];
        slot2_kind <= n_kind[1];
        slot3_kind <= n_kind[2];
        slot4_kind <= n_kind[3];
        {slot4_wb, slot3_wb, slot2_wb, slot1_wb} <= n_wb;
        br_valid <= 1'(lfsr_bits(1));
        br_taken <= 1'(lfsr_bits(1));
        br_correct <= 1'(lfsr_bits(1));
        br_target <= `WB_AW'(lfsr_bits(`WB_AW));
        ie_in <= ie;
        ie_cause <= 3'(lfsr_bits(3));
        interrupt_in <= intr;
        fault_clear <= clr;
        gpr_rd_addr <= RAW'(lfsr_bits(RAW));
        seg_rd_addr <= RAW'(lfsr_bits(RAW));
        @(negedge clk);
        while (hold && stall) @(negedge clk); // source holds under back-pressure
    endtask

    task automatic idle_cycles(int n);
        for (int i = 0; i < n; i++) begin
            drive_instr(1'b0, op_plain, 0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic wait_drained();
        while (q_addr.size() != 0) idle_cycles(1);
        idle_cycles(`WB_MEM_LAT + 2);
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        test_err0 = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_err0);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        valid_in = 1'b0;
        p_op = op_plain;
        eip_in = '0;
        eflags_in = '0;
        {slot1_data, slot2_data, slot3_data, slot4_data} = '0;
        {slot1_dest, slot2_dest, slot3_dest, slot4_dest} = '0;
        slot1_kind = kind_none;
        slot2_kind = kind_none;
        slot3_kind = kind_none;
        slot4_kind = kind_none;
        {slot1_wb, slot2_wb, slot3_wb, slot4_wb} = '0;
        size = sz_8;
        {br_valid, br_taken, br_correct} = '0;
        br_target = '0;
        {ie_in, interrupt_in, fault_clear} = '0;
        ie_cause = '0;
        gpr_rd_addr = '0;
        seg_rd_addr = '0;
        for (int r = 0; r < `WB_NREGS; r++) begin
            m_gpr[r] = '0;
            m_seg[r] = '0;
        end
        m_eip = '0;
        m_cs = '0;
        m_eflags = '0;
        m_st = st_run;
        m_type = exc_none;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        begin_test("reg_seg");
        for (int i = 0; i < 40; i++) begin
            random_slots(2, 0); // narrow dests force collisions
            drive_instr(1'b1, op_plain, 1, 1'b0, 1'b0, 1'b0);
        end
        idle_cycles(2);
        end_test();

        begin_test("mem_order");
        for (int i = 0; i < 20; i++) begin
            random_slots(3, 2);
            drive_instr(1'b1, op_plain, 1, 1'b0, 1'b0, 1'b0);
            idle_cycles(int'(lfsr_bits(2)));
        end
        wait_drained();
        end_test();

        begin_test("mem_burst");
        for (int i = 0; i < 20; i++) begin
            random_slots(3, 2);
            drive_instr(1'b1, op_plain, 1, 1'b0, 1'b0, 1'b0);
        end
        wait_drained();
        count_check(pushes == pops && pushes == 40,
                    $sformatf("%s: %0d writes queued but %0d drained", cur_test, pushes, pops));
        end_test();

        begin_test("branch_far");
        for (int i = 0; i < 30; i++) begin
            random_slots(3, 1);
            // plain or one of the three far transfers
            drive_instr(1'b1, p_op_e'(3'(lfsr_bits(2) == 0 ? 0 : 2 + lfsr_bits(2) % 3)), 1,
                        1'b0, 1'b0, 1'b0);
        end
        wait_drained();
        end_test();

        begin_test("halt_exc");
        random_slots(3, 0);
        drive_instr(1'b1, op_halt, 1, 1'b0, 1'b0, 1'b0);
        drive_instr(1'b1, op_plain, 0, 1'b0, 1'b0, 1'b0); // blocked while halted
        idle_cycles(1);
        drive_instr(1'b0, op_plain, 0, 1'b0, 1'b1, 1'b0);
        drive_instr(1'b1, op_plain, 1, 1'b0, 1'b0, 1'b0);
        drive_instr(1'b1, op_plain, 0, 1'b1, 1'b0, 1'b0);
        idle_cycles(2);
        drive_instr(1'b0, op_plain, 0, 1'b0, 1'b0, 1'b1);
        drive_instr(1'b1, op_plain, 0, 1'b0, 1'b1, 1'b0);
        idle_cycles(1);
        drive_instr(1'b0, op_plain, 0, 1'b0, 1'b0, 1'b1);
        random_slots(3, 0);
        drive_instr(1'b1, op_plain, 1, 1'b0, 1'b0, 1'b0);
        idle_cycles(2);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
logic/wb_types_pkg.sv
logic/wb_ctrl_pkg.sv
logic/wb_route.sv
logic/arch_state.sv
logic/wb_write_queue.sv
logic/mem_drain_timer.sv
logic/wb_fsm.sv
logic/wb_top.sv
bench/wb_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= wb_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
